/* filelist.f */
rtl/mem_bus_pkg.sv
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/dcache_controller.sv
rtl/icache_controller.sv
rtl/mem_arbiter.sv
rtl/cache_subsystem.sv
test/tb_mem_model.sv
test/tb_cache_subsystem.sv

/* rtl/cache_array.sv */
`timescale 1ns/10ps

module cache_array #(
	parameter type line_t = logic,
	parameter int NUM_LINES = 32
)(
	input  logic                         clock,
	input  logic                         reset,
	input  logic [$clog2(NUM_LINES)-1:0] rd_index,
	input  logic                         wr_en,
	input  logic [$clog2(NUM_LINES)-1:0] wr_index,
	input  line_t                        wr_line,
	output line_t                        rd_line
);

	line_t lines [NUM_LINES];

	// lookup is combinational so the controller can compare tags in the same cycle
	assign rd_line = lines[rd_index];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// all lines start invalid and clean
			for (int i = 0; i < NUM_LINES; i++)
			begin
				lines[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			lines[wr_index] <= wr_line;
		end
	end

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

	localparam int BLOCK_OFFSET_W = 3;
	localparam int DCACHE_INDEX_W = 5;
	localparam int ICACHE_INDEX_W = 4;
	localparam int DCACHE_LINES = 1 << DCACHE_INDEX_W;
	localparam int ICACHE_LINES = 1 << ICACHE_INDEX_W;
	localparam int DCACHE_TAG_W = mem_bus_pkg::MEM_ADDR_W - BLOCK_OFFSET_W - DCACHE_INDEX_W;
	localparam int ICACHE_TAG_W = mem_bus_pkg::MEM_ADDR_W - BLOCK_OFFSET_W - ICACHE_INDEX_W;

	typedef logic [BLOCK_OFFSET_W-1:0] block_offset_t;
	typedef logic [DCACHE_INDEX_W-1:0] dcache_index_t;
	typedef logic [ICACHE_INDEX_W-1:0] icache_index_t;
	typedef logic [DCACHE_TAG_W-1:0] dcache_tag_t;
	typedef logic [ICACHE_TAG_W-1:0] icache_tag_t;

	// byte address split into tag, index and offset
	typedef struct packed
	{
		dcache_tag_t   tag;
		dcache_index_t index;
		block_offset_t offset;
	} dcache_addr_t;

	typedef struct packed
	{
		icache_tag_t   tag;
		icache_index_t index;
		block_offset_t offset;
	} icache_addr_t;

	typedef struct packed
	{
		logic                valid;
		logic                dirty;
		dcache_tag_t         tag;
		mem_bus_pkg::block_t data;
	} dcache_line_t;

	typedef struct packed
	{
		logic                valid;
		icache_tag_t         tag;
		mem_bus_pkg::block_t data;
	} icache_line_t;

	typedef struct packed
	{
		mem_bus_pkg::bus_command_t command;
		mem_bus_pkg::mem_addr_t    addr;
		mem_bus_pkg::block_t       data;
	} dcache_req_t;

	typedef struct packed
	{
		mem_bus_pkg::block_t data;
		logic                hit;
	} dcache_result_t;

	typedef struct packed
	{
		mem_bus_pkg::mem_addr_t addr;
	} icache_req_t;

endpackage

/* rtl/cache_subsystem.sv */
`timescale 1ns/10ps

module cache_subsystem (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dcache_req_valid,
	input  cache_pkg::dcache_req_t    dcache_req,
	output logic                      dcache_done,
	output cache_pkg::dcache_result_t dcache_result,
	input  logic                      icache_req_valid,
	input  cache_pkg::icache_req_t    icache_req,
	output logic                      icache_done,
	output mem_bus_pkg::block_t       icache_data,
	output mem_bus_pkg::mem_req_t     mem_req,
	input  mem_bus_pkg::mem_tag_t     mem_response,
	input  mem_bus_pkg::mem_tag_t     mem_tag,
	input  mem_bus_pkg::block_t       mem_data
);

	cache_pkg::dcache_index_t dcache_index;
	cache_pkg::dcache_line_t  dcache_line;
	cache_pkg::dcache_line_t  dcache_wr_line;
	logic                     dcache_wr_en;
	cache_pkg::icache_index_t icache_index;
	cache_pkg::icache_line_t  icache_line;
	cache_pkg::icache_line_t  icache_wr_line;
	logic                     icache_wr_en;
	mem_bus_pkg::mem_req_t    dcache_mem_req;
	mem_bus_pkg::mem_req_t    icache_mem_req;
	logic                     dcache_grant;
	logic                     icache_grant;
	mem_bus_pkg::mem_tag_t    dcache_mem_tag;
	mem_bus_pkg::mem_tag_t    icache_mem_tag;

	// controller reads and writes the same line, so one index serves both ports
	cache_array #(
		.line_t    (cache_pkg::dcache_line_t),
		.NUM_LINES (cache_pkg::DCACHE_LINES)
	) dcache_array0 (
		.clock    (clock),
		.reset    (reset),
		.rd_index (dcache_index),
		.wr_en    (dcache_wr_en),
		.wr_index (dcache_index),
		.wr_line  (dcache_wr_line),
		.rd_line  (dcache_line)
	);

	cache_array #(
		.line_t    (cache_pkg::icache_line_t),
		.NUM_LINES (cache_pkg::ICACHE_LINES)
	) icache_array0 (
		.clock    (clock),
		.reset    (reset),
		.rd_index (icache_index),
		.wr_en    (icache_wr_en),
		.wr_index (icache_index),
		.wr_line  (icache_wr_line),
		.rd_line  (icache_line)
	);

	dcache_controller dcache_ctrl0 (
		.clock            (clock),
		.reset            (reset),
		.dcache_req_valid (dcache_req_valid),
		.dcache_req       (dcache_req),
		.dcache_done      (dcache_done),
		.dcache_result    (dcache_result),
		.array_index      (dcache_index),
		.array_line       (dcache_line),
		.array_wr_en      (dcache_wr_en),
		.array_wr_line    (dcache_wr_line),
		.mem_req          (dcache_mem_req),
		.mem_grant        (dcache_grant),
		.mem_response     (mem_response),
		.mem_tag          (dcache_mem_tag),
		.mem_data         (mem_data)
	);

	icache_controller icache_ctrl0 (
		.clock            (clock),
		.reset            (reset),
		.icache_req_valid (icache_req_valid),
		.icache_req       (icache_req),
		.icache_done      (icache_done),
		.icache_data      (icache_data),
		.array_index      (icache_index),
		.array_line       (icache_line),
		.array_wr_en      (icache_wr_en),
		.array_wr_line    (icache_wr_line),
		.mem_req          (icache_mem_req),
		.mem_grant        (icache_grant),
		.mem_response     (mem_response),
		.mem_tag          (icache_mem_tag),
		.mem_data         (mem_data)
	);

	mem_arbiter arbiter0 (
		.clock          (clock),
		.reset          (reset),
		.dcache_mem_req (dcache_mem_req),
		.icache_mem_req (icache_mem_req),
		.dcache_grant   (dcache_grant),
		.icache_grant   (icache_grant),
		.mem_req        (mem_req),
		.mem_response   (mem_response),
		.mem_tag        (mem_tag),
		.dcache_mem_tag (dcache_mem_tag),
		.icache_mem_tag (icache_mem_tag)
	);

endmodule

/* rtl/dcache_controller.sv */
`timescale 1ns/10ps

module dcache_controller (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dcache_req_valid,
	input  cache_pkg::dcache_req_t    dcache_req,
	output logic                      dcache_done,
	output cache_pkg::dcache_result_t dcache_result,
	output cache_pkg::dcache_index_t  array_index,
	input  cache_pkg::dcache_line_t   array_line,
	output logic                      array_wr_en,
	output cache_pkg::dcache_line_t   array_wr_line,
	output mem_bus_pkg::mem_req_t     mem_req,
	input  logic                      mem_grant,
	input  mem_bus_pkg::mem_tag_t     mem_response,
	input  mem_bus_pkg::mem_tag_t     mem_tag,
	input  mem_bus_pkg::block_t       mem_data
);

	typedef enum logic [2:0]
	{
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL_REQ,
		FILL_WAIT
	} state_t;

	state_t                 state;
	state_t                 next_state;
	cache_pkg::dcache_req_t req_q;
	cache_pkg::dcache_addr_t req_addr;
	mem_bus_pkg::mem_tag_t  fill_tag_q;
	logic                   missed_q;
	logic                   is_store;
	logic                   hit;
	logic                   victim_dirty;
	logic                   fill_arrived;

	assign req_addr = cache_pkg::dcache_addr_t'(req_q.addr);
	assign is_store = (req_q.command == mem_bus_pkg::BUS_STORE);
	assign hit = array_line.valid && (array_line.tag == req_addr.tag);
	// a miss onto a modified line must push it out first
	assign victim_dirty = array_line.valid && array_line.dirty && !hit;
	assign fill_arrived = (mem_tag != '0) && (mem_tag == fill_tag_q);
	assign array_index = req_addr.index;

	// loads need a hit, whole-block stores only need a clean victim
	assign dcache_done = (state == LOOKUP) && !victim_dirty && (hit || is_store);
	assign dcache_result.data = array_line.data;
	assign dcache_result.hit = !missed_q;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (dcache_req_valid)
					next_state = LOOKUP;
			LOOKUP:
				if (victim_dirty)
					next_state = WRITEBACK;
				else if (hit || is_store)
					next_state = IDLE;
				else
					next_state = FILL_REQ;
			WRITEBACK:
				if (mem_grant)
					next_state = is_store ? LOOKUP : FILL_REQ;
			FILL_REQ:
				if (mem_grant)
					next_state = FILL_WAIT;
			FILL_WAIT:
				// back through lookup, which then hits on the new line
				if (fill_arrived)
					next_state = LOOKUP;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			missed_q <= 1'b0;
			fill_tag_q <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == IDLE)
				missed_q <= 1'b0;
			else if ((state == LOOKUP) && (next_state != IDLE))
				missed_q <= 1'b1;
			if ((state == FILL_REQ) && mem_grant)
				fill_tag_q <= mem_response;
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == IDLE) && dcache_req_valid)
			req_q <= dcache_req;
	end

	// array updates: store install, write-back completion, fill
	always_comb
	begin
		array_wr_en = 1'b0;
		array_wr_line.valid = 1'b1;
		array_wr_line.dirty = 1'b1;
		array_wr_line.tag = req_addr.tag;
		array_wr_line.data = req_q.data;
		case (state)
			LOOKUP:
				array_wr_en = is_store && !victim_dirty;
			WRITEBACK:
				array_wr_en = is_store && mem_grant;
			FILL_WAIT:
			begin
				array_wr_en = fill_arrived;
				array_wr_line.dirty = 1'b0;
				array_wr_line.data = mem_data;
			end
			default:
				array_wr_en = 1'b0;
		endcase
	end

	always_comb
	begin
		mem_req = '0;
		case (state)
			WRITEBACK:
			begin
				mem_req.command = mem_bus_pkg::BUS_STORE;
				mem_req.addr = {array_line.tag, req_addr.index,
					{cache_pkg::BLOCK_OFFSET_W{1'b0}}};
				mem_req.data = array_line.data;
			end
			FILL_REQ:
			begin
				mem_req.command = mem_bus_pkg::BUS_LOAD;
				mem_req.addr = {req_addr.tag, req_addr.index,
					{cache_pkg::BLOCK_OFFSET_W{1'b0}}};
			end
			default:
				mem_req.command = mem_bus_pkg::BUS_NONE;
		endcase
	end

endmodule

/* rtl/icache_controller.sv */
`timescale 1ns/10ps

module icache_controller (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     icache_req_valid,
	input  cache_pkg::icache_req_t   icache_req,
	output logic                     icache_done,
	output mem_bus_pkg::block_t      icache_data,
	output cache_pkg::icache_index_t array_index,
	input  cache_pkg::icache_line_t  array_line,
	output logic                     array_wr_en,
	output cache_pkg::icache_line_t  array_wr_line,
	output mem_bus_pkg::mem_req_t    mem_req,
	input  logic                     mem_grant,
	input  mem_bus_pkg::mem_tag_t    mem_response,
	input  mem_bus_pkg::mem_tag_t    mem_tag,
	input  mem_bus_pkg::block_t      mem_data
);

	typedef enum logic [1:0]
	{
		IDLE,
		LOOKUP,
		REQUEST,
		WAIT
	} state_t;

	state_t                  state;
	state_t                  next_state;
	cache_pkg::icache_addr_t fetch_addr_q;
	mem_bus_pkg::mem_tag_t   fill_tag_q;
	logic                    hit;
	logic                    fill_arrived;

	assign hit = array_line.valid && (array_line.tag == fetch_addr_q.tag);
	assign fill_arrived = (mem_tag != '0) && (mem_tag == fill_tag_q);
	assign array_index = fetch_addr_q.index;

	assign icache_done = (state == LOOKUP) && hit;
	assign icache_data = array_line.data;

	// fills are always clean, there is nothing to write back
	assign array_wr_en = (state == WAIT) && fill_arrived;
	assign array_wr_line.valid = 1'b1;
	assign array_wr_line.tag = fetch_addr_q.tag;
	assign array_wr_line.data = mem_data;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (icache_req_valid)
					next_state = LOOKUP;
			LOOKUP:
				next_state = hit ? IDLE : REQUEST;
			REQUEST:
				if (mem_grant)
					next_state = WAIT;
			WAIT:
				if (fill_arrived)
					next_state = LOOKUP;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			fill_tag_q <= '0;
		end
		else
		begin
			state <= next_state;
			if ((state == REQUEST) && mem_grant)
				fill_tag_q <= mem_response;
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == IDLE) && icache_req_valid)
			fetch_addr_q <= cache_pkg::icache_addr_t'(icache_req.addr);
	end

	always_comb
	begin
		mem_req = '0;
		if (state == REQUEST)
		begin
			mem_req.command = mem_bus_pkg::BUS_LOAD;
			mem_req.addr = {fetch_addr_q.tag, fetch_addr_q.index,
				{cache_pkg::BLOCK_OFFSET_W{1'b0}}};
		end
	end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_bus_pkg::mem_req_t dcache_mem_req,
	input  mem_bus_pkg::mem_req_t icache_mem_req,
	output logic                  dcache_grant,
	output logic                  icache_grant,
	output mem_bus_pkg::mem_req_t mem_req,
	input  mem_bus_pkg::mem_tag_t mem_response,
	input  mem_bus_pkg::mem_tag_t mem_tag,
	output mem_bus_pkg::mem_tag_t dcache_mem_tag,
	output mem_bus_pkg::mem_tag_t icache_mem_tag
);

	logic [mem_bus_pkg::NUM_MEM_TAGS-1:0] tag_busy_q;
	logic [mem_bus_pkg::NUM_MEM_TAGS-1:0] tag_icache_q;
	logic                                 dcache_pending;
	logic                                 icache_pending;
	logic                                 load_issued;

	assign dcache_pending = (dcache_mem_req.command != mem_bus_pkg::BUS_NONE);
	assign icache_pending = (icache_mem_req.command != mem_bus_pkg::BUS_NONE);

	// data side first so a victim write-back always beats its own refill
	assign dcache_grant = dcache_pending;
	assign icache_grant = icache_pending && !dcache_pending;
	assign mem_req = dcache_pending ? dcache_mem_req : icache_mem_req;

	// only loads come back with data
	assign load_issued = (mem_req.command == mem_bus_pkg::BUS_LOAD) && (mem_response != '0);

	// a returning tag goes only to the cache that was handed it
	always_comb
	begin
		dcache_mem_tag = '0;
		icache_mem_tag = '0;
		if (tag_busy_q[mem_tag])
		begin
			if (tag_icache_q[mem_tag])
				icache_mem_tag = mem_tag;
			else
				dcache_mem_tag = mem_tag;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tag_busy_q <= '0;
		end
		else
		begin
			// a reissue in the same cycle overrides the retire on delivery
			if (tag_busy_q[mem_tag])
				tag_busy_q[mem_tag] <= 1'b0;
			if (load_issued)
				tag_busy_q[mem_response] <= 1'b1;
		end
	end

	// which cache owns each issued load tag
	always_ff @(posedge clock)
	begin
		if (load_issued)
			tag_icache_q[mem_response] <= icache_grant;
	end

endmodule

/* rtl/mem_bus_pkg.sv */
package mem_bus_pkg;

	localparam int MEM_ADDR_W = 32;
	localparam int BLOCK_W = 64;
	localparam int MEM_TAG_W = 4;
	// tag zero is reserved for "no transaction"
	localparam int NUM_MEM_TAGS = 1 << MEM_TAG_W;

	typedef enum logic [1:0]
	{
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_t;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [MEM_TAG_W-1:0] mem_tag_t;

	// one command on the shared bus, address is block aligned
	typedef struct packed
	{
		bus_command_t command;
		mem_addr_t    addr;
		block_t       data;
	} mem_req_t;

endpackage

/* test/tb_cache_subsystem.sv */
`timescale 1ns/10ps

module tb_cache_subsystem;

	localparam int RESET_CYCLES = 10;
	localparam int OP_TIMEOUT = 100;
	localparam int NUM_DATA_OPS = 300;
	localparam int NUM_FETCHES = 200;
	localparam int NUM_DATA_ADDRS = 16;
	localparam int FETCH_BASE = 32'h4000;

	logic                      clock;
	logic                      reset;
	logic                      dcache_req_valid;
	cache_pkg::dcache_req_t    dcache_req;
	logic                      dcache_done;
	cache_pkg::dcache_result_t dcache_result;
	logic                      icache_req_valid;
	cache_pkg::icache_req_t    icache_req;
	logic                      icache_done;
	mem_bus_pkg::block_t       icache_data;
	mem_bus_pkg::mem_req_t     mem_req;
	mem_bus_pkg::mem_tag_t     mem_response;
	mem_bus_pkg::mem_tag_t     mem_tag;
	mem_bus_pkg::block_t       mem_data;

	integer seed;
	int     error_count;
	int     timeout_count;

	// latest value per data address and the address each dcache index holds
	mem_bus_pkg::block_t ref_data [NUM_DATA_ADDRS];
	int                  resident_k [4];
	logic                resident_dirty [4];

	// data side bus activity during the current request
	mem_bus_pkg::bus_command_t data_cmd_seen;
	logic                      wb_seen;
	mem_bus_pkg::mem_addr_t    wb_addr_seen;
	mem_bus_pkg::block_t       wb_data_seen;

	cache_subsystem dut0 (
		.clock            (clock),
		.reset            (reset),
		.dcache_req_valid (dcache_req_valid),
		.dcache_req       (dcache_req),
		.dcache_done      (dcache_done),
		.dcache_result    (dcache_result),
		.icache_req_valid (icache_req_valid),
		.icache_req       (icache_req),
		.icache_done      (icache_done),
		.icache_data      (icache_data),
		.mem_req          (mem_req),
		.mem_response     (mem_response),
		.mem_tag          (mem_tag),
		.mem_data         (mem_data)
	);

	tb_mem_model mem0 (
		.clock        (clock),
		.reset        (reset),
		.mem_req      (mem_req),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data)
	);

	always #10 clock = ~clock;

	// four tags alias onto each of four dcache indices
	function automatic mem_bus_pkg::mem_addr_t data_addr(int k);
		return mem_bus_pkg::mem_addr_t'(((k >> 2) << 8) | ((k & 3) << 3));
	endfunction

	function automatic mem_bus_pkg::block_t preload_block(mem_bus_pkg::mem_addr_t addr);
		return {addr ^ 32'ha5c3_0f1e, ~addr};
	endfunction

	task automatic check_block(string name, mem_bus_pkg::block_t expected,
		mem_bus_pkg::block_t actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_command(string name, mem_bus_pkg::bus_command_t expected,
		mem_bus_pkg::bus_command_t actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_addr(string name, mem_bus_pkg::mem_addr_t expected,
		mem_bus_pkg::mem_addr_t actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL %s expected %b actual %b", name, expected, actual);
		end
	endtask

	// record commands below the fetch region
	always @(negedge clock)
	begin
		if (!reset && (mem_req.command != mem_bus_pkg::BUS_NONE)
			&& (mem_req.addr < FETCH_BASE))
		begin
			data_cmd_seen = mem_req.command;
			if (mem_req.command == mem_bus_pkg::BUS_STORE)
			begin
				wb_seen = 1'b1;
				wb_addr_seen = mem_req.addr;
				wb_data_seen = mem_req.data;
			end
		end
	end

	task automatic run_data_op(int k, logic store, mem_bus_pkg::block_t wdata);
		mem_bus_pkg::mem_addr_t addr;
		mem_bus_pkg::mem_addr_t victim_addr;
		int                     idx;
		int                     victim;
		int                     cycles;
		logic                   exp_hit;
		logic                   exp_wb;
		logic                   done_seen;
		addr = data_addr(k);
		idx = k & 3;
		victim = resident_k[idx];
		exp_hit = (victim == k);
		exp_wb = (victim >= 0) && (victim != k) && resident_dirty[idx];
		@(posedge clock);
		#1;
		data_cmd_seen = mem_bus_pkg::BUS_NONE;
		wb_seen = 1'b0;
		dcache_req_valid = 1'b1;
		dcache_req.command = store ? mem_bus_pkg::BUS_STORE : mem_bus_pkg::BUS_LOAD;
		dcache_req.addr = addr;
		dcache_req.data = wdata;
		@(posedge clock);
		#1;
		dcache_req_valid = 1'b0;
		cycles = 0;
		done_seen = 1'b0;
		while (!done_seen && (cycles < OP_TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
			if (dcache_done)
				done_seen = 1'b1;
			else
				@(posedge clock);
		end
		if (!done_seen)
		begin
			timeout_count++;
			$display("data request to %h did not complete within %0d cycles", addr, OP_TIMEOUT);
		end
		else
		begin
			if (!store)
			begin
				check_block("load data", ref_data[k], dcache_result.data);
				check_flag("load hit flag", exp_hit, dcache_result.hit);
			end
			else
				check_flag("store hit flag", !exp_wb, dcache_result.hit);
			if (!store && exp_hit && (cycles != 1))
			begin
				error_count++;
				$display("FAIL load hit latency expected 1 actual %0d", cycles);
			end
			@(posedge clock);
			if (!store && exp_hit)
				check_command("load hit bus", mem_bus_pkg::BUS_NONE, data_cmd_seen);
			check_flag("writeback issued", exp_wb, wb_seen);
			if (exp_wb && wb_seen)
			begin
				victim_addr = data_addr(victim);
				check_addr("writeback address", victim_addr, wb_addr_seen);
				check_block("writeback data", ref_data[victim], wb_data_seen);
				check_block("memory word", ref_data[victim], mem0.words[victim_addr[14:3]]);
			end
		end
		if (store)
			ref_data[k] = wdata;
		resident_dirty[idx] = store ? 1'b1 : (exp_hit ? resident_dirty[idx] : 1'b0);
		resident_k[idx] = k;
	endtask

	task automatic run_fetch(int j);
		mem_bus_pkg::mem_addr_t addr;
		int                     cycles;
		logic                   done_seen;
		addr = mem_bus_pkg::mem_addr_t'(FETCH_BASE + (j << 3));
		@(posedge clock);
		#1;
		icache_req_valid = 1'b1;
		icache_req.addr = addr;
		@(posedge clock);
		#1;
		icache_req_valid = 1'b0;
		cycles = 0;
		done_seen = 1'b0;
		while (!done_seen && (cycles < OP_TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
			if (icache_done)
				done_seen = 1'b1;
			else
				@(posedge clock);
		end
		if (!done_seen)
		begin
			timeout_count++;
			$display("fetch from %h did not complete within %0d cycles", addr, OP_TIMEOUT);
		end
		else
			check_block("fetch data", preload_block(addr), icache_data);
		@(posedge clock);
	endtask

	task automatic data_stream();
		int k;
		for (int n = 0; n < NUM_DATA_OPS; n++)
		begin
			k = $unsigned($random(seed)) % NUM_DATA_ADDRS;
			run_data_op(k, $random(seed) & 1, {$random(seed), $random(seed)});
			// an immediate reload of the same address should hit
			if (($unsigned($random(seed)) % 3) == 0)
				run_data_op(k, 1'b0, '0);
			repeat ($unsigned($random(seed)) % 3) @(posedge clock);
		end
	endtask

	task automatic fetch_stream();
		for (int n = 0; n < NUM_FETCHES; n++)
		begin
			// 32 blocks over 16 icache lines
			run_fetch($unsigned($random(seed)) % 32);
			repeat ($unsigned($random(seed)) % 4) @(posedge clock);
		end
	endtask

	initial
	begin
		seed = 32'h5bd53a67;
		error_count = 0;
		timeout_count = 0;
		clock = 1'b0;
		reset = 1'b1;
		dcache_req_valid = 1'b0;
		dcache_req = '0;
		icache_req_valid = 1'b0;
		icache_req = '0;
		data_cmd_seen = mem_bus_pkg::BUS_NONE;
		wb_seen = 1'b0;
		for (int k = 0; k < NUM_DATA_ADDRS; k++)
		begin
			ref_data[k] = preload_block(data_addr(k));
		end
		for (int i = 0; i < 4; i++)
		begin
			resident_k[i] = -1;
			resident_dirty[i] = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (2)
		begin
			@(negedge clock);
			check_command("idle bus", mem_bus_pkg::BUS_NONE, mem_req.command);
			check_flag("idle dcache done", 1'b0, dcache_done);
			check_flag("idle icache done", 1'b0, icache_done);
		end
		fork
			data_stream();
			fetch_stream();
		join
		$display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
		if ((error_count == 0) && (timeout_count == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_bus_pkg::mem_req_t mem_req,
	output mem_bus_pkg::mem_tag_t mem_response,
	output mem_bus_pkg::mem_tag_t mem_tag,
	output mem_bus_pkg::block_t   mem_data
);

	localparam int NUM_WORDS = 4096;

	mem_bus_pkg::block_t   words [NUM_WORDS];
	mem_bus_pkg::mem_tag_t next_tag;
	mem_bus_pkg::mem_tag_t pend_tag [$];
	mem_bus_pkg::block_t   pend_data [$];
	int                    pend_due [$];
	int                    cycle;
	int                    lat;
	int                    hit_i;
	logic                  found;
	logic                  advance;
	integer                seed;

	function automatic mem_bus_pkg::block_t preload_block(mem_bus_pkg::mem_addr_t addr);
		return {addr ^ 32'ha5c3_0f1e, ~addr};
	endfunction

	initial
	begin
		seed = 32'h5bd53a67;
		next_tag = 4'd1;
		cycle = 0;
		advance = 1'b0;
		mem_tag = '0;
		mem_data = '0;
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			words[i] = preload_block(mem_bus_pkg::mem_addr_t'(i << 3));
		end
	end

	// every command is accepted on the spot
	assign mem_response = (mem_req.command != mem_bus_pkg::BUS_NONE) ? next_tag : '0;

	// commands taken mid-cycle where the bus has settled
	always @(negedge clock)
	begin
		advance = 1'b0;
		if (!reset && (mem_req.command != mem_bus_pkg::BUS_NONE))
		begin
			advance = 1'b1;
			if (mem_req.command == mem_bus_pkg::BUS_STORE)
				words[mem_req.addr[14:3]] = mem_req.data;
			else if (mem_req.command == mem_bus_pkg::BUS_LOAD)
			begin
				lat = 1 + ($unsigned($random(seed)) % 4);
				pend_tag.push_back(next_tag);
				pend_data.push_back(words[mem_req.addr[14:3]]);
				pend_due.push_back(cycle + lat);
			end
		end
	end

	// at most one load returns per cycle, oldest due first
	always @(posedge clock)
	begin
		#1;
		cycle = cycle + 1;
		if (advance)
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
		advance = 1'b0;
		mem_tag = '0;
		mem_data = '0;
		found = 1'b0;
		hit_i = 0;
		for (int i = 0; i < pend_due.size(); i++)
		begin
			if (!found && (pend_due[i] <= cycle))
			begin
				found = 1'b1;
				hit_i = i;
			end
		end
		if (found)
		begin
			mem_tag = pend_tag[hit_i];
			mem_data = pend_data[hit_i];
			pend_tag.delete(hit_i);
			pend_data.delete(hit_i);
			pend_due.delete(hit_i);
		end
	end

endmodule
